// File: design/ldpc_pkg.sv
`default_nettype none

package ldpc_pkg;

  // --------------------------------------------------------------------------
  // code geometry
  // --------------------------------------------------------------------------
  localparam int code_n         = 2048;
  localparam int code_k         = 1024;
  localparam int parity_len     = code_n - code_k;
  localparam int circ_size      = 128;
  localparam int circ_cnt       = 8;          // circulants per row, also block rows.
  localparam int data_w         = 8;
  localparam int info_beats     = code_k / data_w;
  localparam int parity_beats   = parity_len / data_w;
  localparam int beats_per_circ = circ_size / data_w;

  // --------------------------------------------------------------------------
  // first row of each block row of the generator, circulant 1 in the msbs.
  // --------------------------------------------------------------------------
  localparam logic [parity_len-1:0] gen_first_rows [circ_cnt] = '{
    {128'hCFA794F49FA5A0D88BB31D8FCA7EA8BB,
     128'hA7AE7EE8A68580E3E922F9E13359B284,
     128'h91F72AE8F2D6BF7830A1F83B3CDBD463,
     128'hCE95C0EC1F609370D7E791C870229C1E,
     128'h71EF3FDF60E2878478934DB285DEC9DC,
     128'h0E95C103008B6BCDD2DAF85CAE732210,
     128'h8326EE83C1FBA56FDD15B2DDB31FE7F2,
     128'h3BA0BB43F83C67BDA1F6AEE46AEF4E62},
    {128'h565083780CA89ACAA70CCFB4A888AE35,
     128'h1210FAD0EC9602CC8C96B0A86D3996A3,
     128'hC0B07FDDA73454C25295F72BD5004E80,
     128'hACCF973FC30261C990525AA0CBA006BD,
     128'h9F079F09A405F7F87AD98429096F2A7E,
     128'hEB8C9B13B84C06E42843A47689A9C528,
     128'hDAAA1A175F598DCFDBAD426CA43AD479,
     128'h1BA78326E75F38EB6ED09A45303A6425},
    {128'h48F42033B7B9A05149DC839C90291E98,
     128'h9B2CEBE50A7C2C264FC6E7D674063589,
     128'hF5B6DEAEBF72106BA9E6676564C17134,
     128'h6D5954558D23519150AAF88D7008E634,
     128'h1FA962FBAB864A5F867C9D6CF4E087AA,
     128'h5D7AA674BA4B1D8CD7AE9186F1D3B23B,
     128'h047F112791EE97B63FB7B58FF3B94E95,
     128'h93BE39A6365C66B877AD316965A72F5B},
    {128'h1B58F88E49C00DC6B35855BFF228A088,
     128'h5C8ED47B61EEC66B5004FB6E65CBECF3,
     128'h77789998FE80925E0237F570E04C5F5B,
     128'hED677661EB7FC3825AB5D5D968C0808C,
     128'h2BDB828B19593F41671B8D0D41DF136C,
     128'hCB47553C9B3F0EA016CC1554C35E6A7D,
     128'h97587FEA91D2098E126EA73CC78658A6,
     128'hADE19711208186CA95C7417A15690C45},
    {128'hBE9C169D889339D9654C976A85CFD9F7,
     128'h47C4148E3B4712DAA3BAD1AD71873D3A,
     128'h1CD630C342C5EBB9183ADE9BEF294E8E,
     128'h7014C077A5F96F75BE566C866964D01C,
     128'hE72AC43A35AD216672EBB3259B77F9BB,
     128'h18DA8B09194FA1F0E876A080C9D6A39F,
     128'h809B168A3D88E8E93D995CE5232C2DC2,
     128'hC7CFA44A363F628A668D46C398CAF96F},
    {128'hD57DBB24AE27ACA1716F8EA1B8AA1086,
     128'h7B7796F4A86F1FD54C7576AD01C68953,
     128'hE75BE799024482368F069658F7AAAFB0,
     128'h975F3AF795E78D255871C71B4F4B77F6,
     128'h65CD9C359BB2A82D5353E007166BDD41,
     128'h2C5447314DB027B10B130071AD0398D1,
     128'hDE19BC7A6BBCF6A0FF021AABF12920A5,
     128'h58BAED484AF89E29D4DBC170CEF1D369},
    {128'h4C330B2D11E15B5CB3815E09605338A6,
     128'h75E3D1A3541E0E284F6556D68D3C8A9E,
     128'hE5BB3B297DB62CD2907F09996967A0F4,
     128'hFF33AEEE2C8A4A52FCCF5C39D355C39C,
     128'h5FE5F09ABA6BCCE02A73401E5F87EAC2,
     128'hD75702F4F57670DFA70B1C002F523EEA,
     128'h6CE1CE2E05D420CB867EC0166B8E53A9,
     128'h9DF9801A1C33058DD116A0AE7278BBB9},
    {128'h4CF0B0C792DD8FDB3ECEAE6F2B7F663D,
     128'h106A1C296E47C14C1498B045D57DEFB5,
     128'h968F6D8C790263C353CF307EF90C1F21,
     128'h66E6B632F6614E58267EF096C37718A3,
     128'h3D46E5D10E993EB6DF81518F885EDA1B,
     128'h6FF518FD48BB8E9DDBED4AC0F4F5EB89,
     128'hBCC64D21A65DB379ABE2E4DC21F109FF,
     128'h2EC0CE7B5D40973D13ECF713B01C6F10}
  };

  // --------------------------------------------------------------------------
  // controller states
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    st_wait_in,     // s_axis_tready high.
    st_info_out,    // echo of the accepted byte.
    st_parity_gap,
    st_parity_out
  } enc_state_e;

endpackage

`default_nettype wire

// File: design/ldpc_gen_row.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_gen_row (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              info_done,
  output logic [ldpc_pkg::parity_len-1:0]        gen_row
);

  localparam int row_w  = $clog2(ldpc_pkg::circ_cnt);
  localparam int beat_w = $clog2(ldpc_pkg::beats_per_circ);

  logic [row_w-1:0]                 row_idx;
  logic [row_w-1:0]                 row_inc;
  logic [beat_w-1:0]                beat_cnt;
  logic [ldpc_pkg::parity_len-1:0]  row_rot;

  assign row_inc = row_idx + 1'b1;    // wraps from 7 to 0.

  // each circulant moves right by one byte worth of information bits
  always_comb
  begin
    for (int c = 0; c < ldpc_pkg::circ_cnt; c++)
    begin
      row_rot[c*ldpc_pkg::circ_size +: ldpc_pkg::circ_size] =
        {gen_row[c*ldpc_pkg::circ_size +: ldpc_pkg::data_w],
         gen_row[c*ldpc_pkg::circ_size+ldpc_pkg::data_w +:
                 ldpc_pkg::circ_size-ldpc_pkg::data_w]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_idx  <= '0;
      beat_cnt <= '0;
      gen_row  <= ldpc_pkg::gen_first_rows[0];
    end
    else if (info_done)
    begin
      beat_cnt <= beat_cnt + 1'b1;
      if (beat_cnt == beat_w'(ldpc_pkg::beats_per_circ - 1))
      begin
        row_idx <= row_inc;
        gen_row <= ldpc_pkg::gen_first_rows[row_inc];   // next block row.
      end
      else
      begin
        gen_row <= row_rot;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ldpc_parity_acc.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_parity_acc (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                info_done,
  input  wire logic [ldpc_pkg::data_w-1:0]         info_byte,
  input  wire logic [ldpc_pkg::parity_len-1:0]     gen_row,
  input  wire logic                                parity_shift,
  output logic [ldpc_pkg::data_w-1:0]              parity_byte
);

  logic [ldpc_pkg::parity_len-1:0] rot_rows [ldpc_pkg::data_w];
  logic [ldpc_pkg::parity_len-1:0] acc_term;
  logic [ldpc_pkg::parity_len-1:0] parity_reg;

  function automatic logic [ldpc_pkg::circ_size-1:0] circ_rotr(
    input logic [ldpc_pkg::circ_size-1:0] x,
    input int unsigned                    sh
  );
    logic [2*ldpc_pkg::circ_size-1:0] dbl;
    dbl = {x, x} >> sh;
    return dbl[ldpc_pkg::circ_size-1:0];
  endfunction

  // bit i of the byte sits 7-i places after its msb within the circulant.
  for (genvar i = 0; i < ldpc_pkg::data_w; i++)
  begin : g_bit
    for (genvar c = 0; c < ldpc_pkg::circ_cnt; c++)
    begin : g_circ
      assign rot_rows[i][c*ldpc_pkg::circ_size +: ldpc_pkg::circ_size] =
        circ_rotr(gen_row[c*ldpc_pkg::circ_size +: ldpc_pkg::circ_size],
                  ldpc_pkg::data_w - 1 - i);
    end
  end

  always_comb
  begin
    acc_term = '0;
    for (int i = 0; i < ldpc_pkg::data_w; i++)
    begin
      if (info_byte[i])
        acc_term = acc_term ^ rot_rows[i];
    end
  end

  // empties itself after a full block of shifts.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      parity_reg <= '0;
    else if (info_done)
      parity_reg <= parity_reg ^ acc_term;
    else if (parity_shift)
      parity_reg <= {parity_reg[ldpc_pkg::parity_len-ldpc_pkg::data_w-1:0],
                     {ldpc_pkg::data_w{1'b0}}};
  end

  assign parity_byte = parity_reg[ldpc_pkg::parity_len-1 -: ldpc_pkg::data_w];

endmodule

`default_nettype wire

// File: design/ldpc_enc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_enc_ctrl (
  input  wire logic                            clk,
  input  wire logic                            rst_n,

  input  wire logic [ldpc_pkg::data_w-1:0]     s_axis_tdata,
  input  wire logic                            s_axis_tvalid,
  output logic                                 s_axis_tready,

  output logic [ldpc_pkg::data_w-1:0]          m_axis_tdata,
  output logic                                 m_axis_tvalid,
  output logic                                 m_axis_tlast,
  input  wire logic                            m_axis_tready,

  input  wire logic [ldpc_pkg::data_w-1:0]     parity_byte,
  output logic [ldpc_pkg::data_w-1:0]          info_byte,
  output logic                                 info_done,
  output logic                                 parity_shift
);

  localparam int cnt_w = $clog2(ldpc_pkg::info_beats);

  ldpc_pkg::enc_state_e state;
  ldpc_pkg::enc_state_e state_nxt;
  logic [cnt_w-1:0]     beat_cnt;
  logic [cnt_w-1:0]     beat_cnt_nxt;
  logic                 in_xfer;

  assign in_xfer      = s_axis_tvalid && s_axis_tready;
  assign info_done    = (state == ldpc_pkg::st_info_out) && m_axis_tready;
  assign parity_shift = (state == ldpc_pkg::st_parity_out) && m_axis_tready;

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb
  begin
    state_nxt    = state;
    beat_cnt_nxt = beat_cnt;
    case (state)
      ldpc_pkg::st_wait_in:
        if (in_xfer)
          state_nxt = ldpc_pkg::st_info_out;
      ldpc_pkg::st_info_out:
        if (info_done)
        begin
          if (beat_cnt == cnt_w'(ldpc_pkg::info_beats - 1))
          begin
            beat_cnt_nxt = '0;
            state_nxt    = ldpc_pkg::st_parity_gap;
          end
          else
          begin
            beat_cnt_nxt = beat_cnt + 1'b1;
            state_nxt    = ldpc_pkg::st_wait_in;
          end
        end
      ldpc_pkg::st_parity_gap:
        state_nxt = ldpc_pkg::st_parity_out;   // parity settles here.
      ldpc_pkg::st_parity_out:
        if (parity_shift)
        begin
          if (beat_cnt == cnt_w'(ldpc_pkg::parity_beats - 1))
          begin
            beat_cnt_nxt = '0;
            state_nxt    = ldpc_pkg::st_wait_in;
          end
          else
          begin
            beat_cnt_nxt = beat_cnt + 1'b1;
          end
        end
      default:
        state_nxt = ldpc_pkg::st_wait_in;
    endcase
  end

  // tready is registered so that it stays low while in reset.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= ldpc_pkg::st_wait_in;
      beat_cnt      <= '0;
      s_axis_tready <= 1'b0;
    end
    else
    begin
      state         <= state_nxt;
      beat_cnt      <= beat_cnt_nxt;
      s_axis_tready <= (state_nxt == ldpc_pkg::st_wait_in);
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_xfer)
      info_byte <= s_axis_tdata;
  end

  // --------------------------------------------------------------------------
  // output side
  // --------------------------------------------------------------------------
  assign m_axis_tvalid = (state == ldpc_pkg::st_info_out) ||
                         (state == ldpc_pkg::st_parity_out);
  assign m_axis_tlast  = (state == ldpc_pkg::st_parity_out) &&
                         (beat_cnt == cnt_w'(ldpc_pkg::parity_beats - 1));

  always_comb
  begin
    case (state)
      ldpc_pkg::st_info_out:   m_axis_tdata = info_byte;     // echo.
      ldpc_pkg::st_parity_out: m_axis_tdata = parity_byte;
      default:                 m_axis_tdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ldpc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_encoder (
  input  wire logic                            clk,
  input  wire logic                            rst_n,

  input  wire logic [ldpc_pkg::data_w-1:0]     s_axis_tdata,
  input  wire logic                            s_axis_tvalid,
  output logic                                 s_axis_tready,

  output logic [ldpc_pkg::data_w-1:0]          m_axis_tdata,
  output logic                                 m_axis_tvalid,
  output logic                                 m_axis_tlast,
  input  wire logic                            m_axis_tready
);

  logic [ldpc_pkg::data_w-1:0]     info_byte;
  logic                            info_done;
  logic                            parity_shift;
  logic [ldpc_pkg::data_w-1:0]     parity_byte;
  logic [ldpc_pkg::parity_len-1:0] gen_row;

  ldpc_enc_ctrl i_ldpc_enc_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .parity_byte   (parity_byte),
    .info_byte     (info_byte),
    .info_done     (info_done),
    .parity_shift  (parity_shift)
  );

  // row for the msb of the byte now on the output.
  ldpc_gen_row i_ldpc_gen_row (
    .clk       (clk),
    .rst_n     (rst_n),
    .info_done (info_done),
    .gen_row   (gen_row)
  );

  ldpc_parity_acc i_ldpc_parity_acc (
    .clk          (clk),
    .rst_n        (rst_n),
    .info_done    (info_done),
    .info_byte    (info_byte),
    .gen_row      (gen_row),
    .parity_shift (parity_shift),
    .parity_byte  (parity_byte)
  );

endmodule

`default_nettype wire

// File: bench/ldpc_encoder_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_encoder_checker (
  input wire logic                          clk,
  input wire logic                          rst_n,
  input wire logic                          s_axis_tready,
  input wire logic [ldpc_pkg::data_w-1:0]   m_axis_tdata,
  input wire logic                          m_axis_tvalid,
  input wire logic                          m_axis_tlast,
  input wire logic                          m_axis_tready
);

  // a stalled output beat holds until it is taken.
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (m_axis_tvalid && !m_axis_tready) |=>
        (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else $error("output beat changed before its transfer");

  a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
      m_axis_tlast |-> m_axis_tvalid)
    else $error("tlast without tvalid");

  a_one_side: assert property (@(posedge clk) disable iff (!rst_n)
      !(s_axis_tready && m_axis_tvalid))
    else $error("input ready while output valid");

  a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> (!s_axis_tready && !m_axis_tvalid && !m_axis_tlast))
    else $error("stream outputs active coming out of reset");

endmodule

bind ldpc_encoder ldpc_encoder_checker i_ldpc_encoder_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .s_axis_tready (s_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tready (m_axis_tready)
);

`default_nettype wire

// File: bench/tb_ldpc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_encoder;

  localparam int max_cycles = 20000;    // five blocks with stall slack, plus reset.
  localparam int blk_beats  = ldpc_pkg::info_beats + ldpc_pkg::parity_beats;
  localparam int pat_len    = 1024;

  logic                          clk;
  logic                          rst_n;
  logic [ldpc_pkg::data_w-1:0]   s_axis_tdata;
  logic                          s_axis_tvalid;
  logic                          s_axis_tready;
  logic [ldpc_pkg::data_w-1:0]   m_axis_tdata;
  logic                          m_axis_tvalid;
  logic                          m_axis_tlast;
  logic                          m_axis_tready;

  logic [ldpc_pkg::data_w-1:0]   blk [2][ldpc_pkg::info_beats];
  int unsigned                   gap_len [2*ldpc_pkg::info_beats];
  logic                          rdy_pat [pat_len];
  logic                          stall_on;
  integer                        seed = 32'hf9f9_3586;
  int                            cycles = 0;

  ldpc_encoder i_ldpc_encoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("timeout: the encoder stopped moving data before all tests finished");
      $display("** FAIL **");
      $fatal(1);
    end
  end

  // output side ready, random low cycles while stalling.
  initial
  begin
    m_axis_tready = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      m_axis_tready = stall_on ? rdy_pat[cycles % pat_len] : 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // checking and reference model
  // --------------------------------------------------------------------------
  task automatic check_eq(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // xor of the rotated block rows over all set information bits.
  function automatic logic [ldpc_pkg::parity_len-1:0] model_parity(input int idx);
    logic [ldpc_pkg::parity_len-1:0] par;
    logic [ldpc_pkg::parity_len-1:0] base;
    int                              r;
    int                              m;
    par = '0;
    for (int j = 0; j < ldpc_pkg::code_k; j++)
    begin
      if (blk[idx][j / ldpc_pkg::data_w][ldpc_pkg::data_w - 1 - j % ldpc_pkg::data_w])
      begin
        r    = j / ldpc_pkg::circ_size;
        m    = j % ldpc_pkg::circ_size;
        base = ldpc_pkg::gen_first_rows[r];
        for (int c = 0; c < ldpc_pkg::circ_cnt; c++)
          for (int k = 0; k < ldpc_pkg::circ_size; k++)
            par[c*ldpc_pkg::circ_size + k] ^=
              base[c*ldpc_pkg::circ_size + (k + m) % ldpc_pkg::circ_size];
      end
    end
    return par;
  endfunction

  // --------------------------------------------------------------------------
  // stream driver and collector
  // --------------------------------------------------------------------------
  task automatic send_block(input int idx, input bit use_gaps);
    logic acc;
    for (int b = 0; b < ldpc_pkg::info_beats; b++)
    begin
      if (use_gaps)
      begin
        s_axis_tvalid = 1'b0;
        repeat (gap_len[idx*ldpc_pkg::info_beats + b])
        begin
          @(posedge clk);
          #1;
        end
      end
      s_axis_tvalid = 1'b1;
      s_axis_tdata  = blk[idx][b];
      do
      begin
        @(negedge clk);
        acc = s_axis_tready;
        @(posedge clk);
        #1;
      end while (!acc);
      s_axis_tvalid = 1'b0;
    end
  endtask

  task automatic collect_block(input string name, input int idx,
                               input logic [ldpc_pkg::parity_len-1:0] exp_par);
    logic [ldpc_pkg::data_w-1:0] exp;
    for (int k = 0; k < blk_beats; k++)
    begin
      do
        @(negedge clk);
      while (!(m_axis_tvalid && m_axis_tready));
      if (k < ldpc_pkg::info_beats)
        exp = blk[idx][k];
      else
        exp = exp_par[ldpc_pkg::parity_len - 1 -
                      ldpc_pkg::data_w*(k - ldpc_pkg::info_beats) -: ldpc_pkg::data_w];
      check_eq(name, exp, m_axis_tdata);
      check_eq(name, 8'(k == blk_beats - 1), 8'(m_axis_tlast));
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_block(input string name, input int idx,
                           input logic [ldpc_pkg::parity_len-1:0] exp_par, input bit use_gaps);
    fork
      send_block(idx, use_gaps);
      collect_block(name, idx, exp_par);
    join
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    repeat (10)
    begin
      @(posedge clk);
      #1;
      check_eq("test_reset", 8'd0, 8'(s_axis_tready));
      check_eq("test_reset", 8'd0, 8'(m_axis_tvalid));
      check_eq("test_reset", 8'd0, 8'(m_axis_tlast));
    end
    rst_n = 1'b1;
    @(posedge clk);   // tready is registered.
    #1;
    check_eq("test_reset", 8'd1, 8'(s_axis_tready));
  endtask

  task automatic test_zero_block();
    for (int b = 0; b < ldpc_pkg::info_beats; b++)
      blk[0][b] = '0;
    run_block("test_zero_block", 0, '0, 1'b0);
  endtask

  task automatic test_single_bit();
    for (int b = 0; b < ldpc_pkg::info_beats; b++)
      blk[0][b] = '0;
    blk[0][0] = 8'h80;
    run_block("test_single_bit", 0, ldpc_pkg::gen_first_rows[0], 1'b0);
  endtask

  task automatic test_random_block();
    for (int b = 0; b < ldpc_pkg::info_beats; b++)
      blk[0][b] = 8'($random(seed));
    run_block("test_random_block", 0, model_parity(0), 1'b0);
  endtask

  task automatic test_backpressure();
    logic [ldpc_pkg::parity_len-1:0] par0;
    logic [ldpc_pkg::parity_len-1:0] par1;
    for (int b = 0; b < ldpc_pkg::info_beats; b++)
    begin
      blk[0][b] = 8'($random(seed));
      blk[1][b] = 8'($random(seed));
    end
    for (int i = 0; i < 2*ldpc_pkg::info_beats; i++)
      gap_len[i] = $unsigned($random(seed)) % 4;
    for (int i = 0; i < pat_len; i++)
      rdy_pat[i] = ($unsigned($random(seed)) % 4) != 0;
    par0 = model_parity(0);
    par1 = model_parity(1);
    @(negedge clk);
    stall_on = 1'b1;
    @(posedge clk);
    #1;
    fork
      begin
        send_block(0, 1'b1);
        send_block(1, 1'b1);
      end
      begin
        collect_block("test_backpressure", 0, par0);
        collect_block("test_backpressure", 1, par1);
      end
    join
    @(negedge clk);
    stall_on = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    rst_n         = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    stall_on      = 1'b0;
    test_reset();
    test_zero_block();
    test_single_bit();
    test_random_block();
    test_backpressure();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
design/ldpc_pkg.sv
design/ldpc_gen_row.sv
design/ldpc_parity_acc.sv
design/ldpc_enc_ctrl.sv
design/ldpc_encoder.sv
bench/ldpc_encoder_checker.sv
bench/tb_ldpc_encoder.sv

// File: run.sh
#!/bin/sh
# Build and run the LDPC encoder testbench with Verilator.
# The simulator exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ldpc_encoder \
  --Mdir obj_dir -o sim_tb \
  -f build.f

./obj_dir/sim_tb
